// ==== Bender.yml ====
package:
  name: copy_unit

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/copy_pkg.sv
      - rtl/copy_job_control.sv
      - rtl/copy_read_engine.sv
      - rtl/copy_line_buffer.sv
      - rtl/copy_write_engine.sv
      - rtl/command_arbiter.sv
      - rtl/copy_unit_top.sv

  - target: simulation
    include_dirs:
      - rtl
    files:
      - testbench/copy_memory_model.sv
      - testbench/copy_unit_tb.sv

// ==== rtl/command_arbiter.sv ====
`timescale 1ns/10ps

module command_arbiter (
	input  logic                clock,
	input  logic                rstn,
	input  logic                cmd_full,
	input  logic                rd_req,
	input  copy_pkg::addr_t     rd_addr,
	input  copy_pkg::count_t    rd_index,
	input  logic                wr_req,
	input  copy_pkg::addr_t     wr_addr,
	input  copy_pkg::count_t    wr_index,
	input  copy_pkg::line_t     wr_data,
	output logic                rd_grant,
	output logic                wr_grant,
	output logic                cmd_valid,
	output copy_pkg::cmd_kind_t cmd_kind,
	output copy_pkg::addr_t     cmd_addr,
	output copy_pkg::count_t    cmd_index,
	output copy_pkg::line_t     cmd_data
);

	// Set when the write engine won the last grant
	logic last_wr;

	////////////////////////////////////////////////////////////
	// Round-robin grant
	////////////////////////////////////////////////////////////

	// On a tie the engine that did not win last goes first
	assign rd_grant = !cmd_full && rd_req && (!wr_req || last_wr);
	assign wr_grant = !cmd_full && wr_req && (!rd_req || !last_wr);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			last_wr   <= 1'b0;
			cmd_valid <= 1'b0;
			cmd_kind  <= copy_pkg::CMD_READ;
		end else begin
			cmd_valid <= rd_grant || wr_grant;
			if (rd_grant || wr_grant) begin
				last_wr  <= wr_grant;
				cmd_kind <= wr_grant ? copy_pkg::CMD_WRITE : copy_pkg::CMD_READ;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Command payload
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (rd_grant || wr_grant) begin
			cmd_addr  <= wr_grant ? wr_addr : rd_addr;
			cmd_index <= wr_grant ? wr_index : rd_index;
			cmd_data  <= wr_data;
		end
	end

endmodule

// ==== rtl/copy_job_control.sv ====
`timescale 1ns/10ps
`include "copy_settings.svh"

module copy_job_control (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        enabled,
	input  logic                        job_start,
	input  copy_pkg::addr_t             job_src,
	input  copy_pkg::addr_t             job_dst,
	input  copy_pkg::count_t            job_size,
	input  logic                        rdata_valid,
	input  logic                        wrsp_valid,
	output logic                        start,
	output copy_pkg::addr_t             src_addr,
	output copy_pkg::addr_t             dst_addr,
	output copy_pkg::count_t            size,
	output logic [2*`CU_COUNT_BITS-1:0] status,
	output logic                        running,
	output logic                        done
);

	copy_pkg::job_state_t state;
	copy_pkg::count_t     rd_count;
	copy_pkg::count_t     wr_count;
	copy_pkg::count_t     rd_count_next;
	copy_pkg::count_t     wr_count_next;
	logic                 accept;

	// Jobs are taken only when idle or finished
	assign accept = enabled && job_start && (state != copy_pkg::JOB_RUN);

	assign rd_count_next = rd_count + copy_pkg::count_t'(rdata_valid);
	assign wr_count_next = wr_count + copy_pkg::count_t'(wrsp_valid);

	////////////////////////////////////////////////////////////
	// Descriptor latch
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (accept) begin
			src_addr <= job_src;
			dst_addr <= job_dst;
			size     <= job_size;
		end
	end

	////////////////////////////////////////////////////////////
	// Job FSM and completion counters
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state    <= copy_pkg::JOB_IDLE;
			start    <= 1'b0;
			rd_count <= '0;
			wr_count <= '0;
		end else begin
			start <= accept;
			if (accept) begin
				state    <= copy_pkg::JOB_RUN;
				rd_count <= '0;
				wr_count <= '0;
			end else if (state == copy_pkg::JOB_RUN) begin
				rd_count <= rd_count_next;
				wr_count <= wr_count_next;
				// Finish on the edge after the last counted event
				if ((rd_count_next == size) && (wr_count_next == size))
					state <= copy_pkg::JOB_DONE;
			end
		end
	end

	// Write count high, read count low
	assign status  = {wr_count, rd_count};
	assign running = (state == copy_pkg::JOB_RUN);
	assign done    = (state == copy_pkg::JOB_DONE);

endmodule

// ==== rtl/copy_line_buffer.sv ====
`timescale 1ns/10ps
`include "copy_settings.svh"

module copy_line_buffer #(
	parameter int depth = `CU_BUF_DEPTH
) (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         push,
	input  copy_pkg::line_t              push_data,
	input  copy_pkg::count_t             push_index,
	input  logic                         buf_pop,
	output copy_pkg::line_t              head_data,
	output copy_pkg::count_t             head_index,
	output logic                         buf_empty,
	output logic [$clog2(depth+1)-1:0]   buf_count
);

	localparam int PTR_BITS = $clog2(depth);

	copy_pkg::line_t  data_mem  [depth];
	copy_pkg::count_t index_mem [depth];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;

	// Head is valid whenever the buffer holds a line
	assign head_data  = data_mem[rd_ptr];
	assign head_index = index_mem[rd_ptr];
	assign buf_empty  = (buf_count == '0);

	////////////////////////////////////////////////////////////
	// Storage
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (push) begin
			data_mem[wr_ptr]  <= push_data;
			index_mem[wr_ptr] <= push_index;
		end
	end

	////////////////////////////////////////////////////////////
	// Pointers and occupancy
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			buf_count <= '0;
		end else begin
			// Explicit wrap so any depth works
			if (push)
				wr_ptr <= (wr_ptr == PTR_BITS'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			if (buf_pop)
				rd_ptr <= (rd_ptr == PTR_BITS'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			case ({push, buf_pop})
				2'b10:   buf_count <= buf_count + 1'b1;
				2'b01:   buf_count <= buf_count - 1'b1;
				default: buf_count <= buf_count;
			endcase
		end
	end

endmodule

// ==== rtl/copy_pkg.sv ====
`include "copy_settings.svh"

package copy_pkg;

	////////////////////////////////////////////////////////////
	// Data types
	////////////////////////////////////////////////////////////

	typedef logic [`CU_ADDR_BITS-1:0] addr_t;

	typedef logic [`CU_DATA_BITS-1:0] line_t;

	typedef logic [`CU_COUNT_BITS-1:0] count_t;

	// Command bus kind
	typedef enum logic {
		CMD_READ,
		CMD_WRITE
	} cmd_kind_t;

	// Job control FSM
	typedef enum logic [1:0] {
		JOB_IDLE,
		JOB_RUN,
		JOB_DONE
	} job_state_t;

endpackage

// ==== rtl/copy_read_engine.sv ====
`timescale 1ns/10ps
`include "copy_settings.svh"

module copy_read_engine (
	input  logic                               clock,
	input  logic                               rstn,
	input  logic                               start,
	input  copy_pkg::addr_t                    src_addr,
	input  copy_pkg::count_t                   size,
	input  logic [$clog2(`CU_BUF_DEPTH+1)-1:0] buf_count,
	input  logic                               rdata_valid,
	input  logic                               rd_grant,
	output logic                               rd_req,
	output copy_pkg::addr_t                    rd_addr,
	output copy_pkg::count_t                   rd_index
);

	localparam int CREDIT_BITS = $clog2(`CU_BUF_DEPTH + 1);

	logic                   active;
	logic [CREDIT_BITS-1:0] outstanding;
	logic [CREDIT_BITS:0]   credit_used;

	// Reads in flight plus lines already buffered
	assign credit_used = {1'b0, outstanding} + {1'b0, buf_count};

	// Credit only shrinks on a grant, so the request holds until granted
	assign rd_req  = active && (credit_used < `CU_BUF_DEPTH);
	assign rd_addr = src_addr + copy_pkg::addr_t'(rd_index) * copy_pkg::addr_t'(`CU_LINE_BYTES);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			active      <= 1'b0;
			rd_index    <= '0;
			outstanding <= '0;
		end else begin
			if (start) begin
				active   <= 1'b1;
				rd_index <= '0;
			end else if (rd_grant) begin
				if (rd_index == size - 1'b1)
					active <= 1'b0;
				rd_index <= rd_index + 1'b1;
			end
			case ({rd_grant, rdata_valid})
				2'b10:   outstanding <= outstanding + 1'b1;
				2'b01:   outstanding <= outstanding - 1'b1;
				default: outstanding <= outstanding;
			endcase
		end
	end

endmodule

// ==== rtl/copy_settings.svh ====
`ifndef COPY_SETTINGS_SVH
`define COPY_SETTINGS_SVH

////////////////////////////////////////////////////////////
// Copy unit widths and depths
////////////////////////////////////////////////////////////

// Byte address on the command bus
`define CU_ADDR_BITS 64

// One cache line of payload
`define CU_DATA_BITS 64

// Line counts and line indices
`define CU_COUNT_BITS 16

// Address step between consecutive lines
`define CU_LINE_BYTES 8

// Entries in the read data buffer, 2 or more
`define CU_BUF_DEPTH 8

`endif

// ==== rtl/copy_unit_top.sv ====
`timescale 1ns/10ps
`include "copy_settings.svh"

module copy_unit_top (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        enabled,
	input  logic                        job_start,
	input  copy_pkg::addr_t             job_src,
	input  copy_pkg::addr_t             job_dst,
	input  copy_pkg::count_t            job_size,
	input  logic                        cmd_full,
	input  logic                        rdata_valid,
	input  copy_pkg::line_t             rdata,
	input  copy_pkg::count_t            rdata_index,
	input  logic                        wrsp_valid,
	output logic                        cmd_valid,
	output copy_pkg::cmd_kind_t         cmd_kind,
	output copy_pkg::addr_t             cmd_addr,
	output copy_pkg::count_t            cmd_index,
	output copy_pkg::line_t             cmd_data,
	output logic [2*`CU_COUNT_BITS-1:0] status,
	output logic                        running,
	output logic                        done
);

	localparam int COUNT_BITS = $clog2(`CU_BUF_DEPTH + 1);

	// Job descriptor
	logic             start;
	copy_pkg::addr_t  src_addr;
	copy_pkg::addr_t  dst_addr;
	copy_pkg::count_t size;

	// Read side
	logic             rd_req;
	logic             rd_grant;
	copy_pkg::addr_t  rd_addr;
	copy_pkg::count_t rd_index;

	// Buffer to write side
	logic                  buf_pop;
	logic                  buf_empty;
	logic [COUNT_BITS-1:0] buf_count;
	copy_pkg::line_t       head_data;
	copy_pkg::count_t      head_index;

	// Write side
	logic             wr_req;
	logic             wr_grant;
	copy_pkg::addr_t  wr_addr;
	copy_pkg::count_t wr_index;
	copy_pkg::line_t  wr_data;

	////////////////////////////////////////////////////////////
	// Job control
	////////////////////////////////////////////////////////////

	copy_job_control copy_job_control_inst (
		.clock      (clock      ),
		.rstn       (rstn       ),
		.enabled    (enabled    ),
		.job_start  (job_start  ),
		.job_src    (job_src    ),
		.job_dst    (job_dst    ),
		.job_size   (job_size   ),
		.rdata_valid(rdata_valid),
		.wrsp_valid (wrsp_valid ),
		.start      (start      ),
		.src_addr   (src_addr   ),
		.dst_addr   (dst_addr   ),
		.size       (size       ),
		.status     (status     ),
		.running    (running    ),
		.done       (done       )
	);

	////////////////////////////////////////////////////////////
	// Engines and line buffer
	////////////////////////////////////////////////////////////

	copy_read_engine copy_read_engine_inst (
		.clock      (clock      ),
		.rstn       (rstn       ),
		.start      (start      ),
		.src_addr   (src_addr   ),
		.size       (size       ),
		.buf_count  (buf_count  ),
		.rdata_valid(rdata_valid),
		.rd_grant   (rd_grant   ),
		.rd_req     (rd_req     ),
		.rd_addr    (rd_addr    ),
		.rd_index   (rd_index   )
	);

	copy_line_buffer #(
		.depth(`CU_BUF_DEPTH)
	) copy_line_buffer_inst (
		.clock     (clock      ),
		.rstn      (rstn       ),
		.push      (rdata_valid),
		.push_data (rdata      ),
		.push_index(rdata_index),
		.buf_pop   (buf_pop    ),
		.head_data (head_data  ),
		.head_index(head_index ),
		.buf_empty (buf_empty  ),
		.buf_count (buf_count  )
	);

	copy_write_engine copy_write_engine_inst (
		.clock     (clock     ),
		.rstn      (rstn      ),
		.dst_addr  (dst_addr  ),
		.buf_empty (buf_empty ),
		.head_data (head_data ),
		.head_index(head_index),
		.wr_grant  (wr_grant  ),
		.buf_pop   (buf_pop   ),
		.wr_req    (wr_req    ),
		.wr_addr   (wr_addr   ),
		.wr_index  (wr_index  ),
		.wr_data   (wr_data   )
	);

	////////////////////////////////////////////////////////////
	// Shared command bus
	////////////////////////////////////////////////////////////

	command_arbiter command_arbiter_inst (
		.clock    (clock    ),
		.rstn     (rstn     ),
		.cmd_full (cmd_full ),
		.rd_req   (rd_req   ),
		.rd_addr  (rd_addr  ),
		.rd_index (rd_index ),
		.wr_req   (wr_req   ),
		.wr_addr  (wr_addr  ),
		.wr_index (wr_index ),
		.wr_data  (wr_data  ),
		.rd_grant (rd_grant ),
		.wr_grant (wr_grant ),
		.cmd_valid(cmd_valid),
		.cmd_kind (cmd_kind ),
		.cmd_addr (cmd_addr ),
		.cmd_index(cmd_index),
		.cmd_data (cmd_data )
	);

endmodule

// ==== rtl/copy_write_engine.sv ====
`timescale 1ns/10ps
`include "copy_settings.svh"

module copy_write_engine (
	input  logic             clock,
	input  logic             rstn,
	input  copy_pkg::addr_t  dst_addr,
	input  logic             buf_empty,
	input  copy_pkg::line_t  head_data,
	input  copy_pkg::count_t head_index,
	input  logic             wr_grant,
	output logic             buf_pop,
	output logic             wr_req,
	output copy_pkg::addr_t  wr_addr,
	output copy_pkg::count_t wr_index,
	output copy_pkg::line_t  wr_data
);

	// Take a new line only with no write pending
	assign buf_pop = !wr_req && !buf_empty;

	// Same line index as the source, in the destination region
	assign wr_addr = dst_addr + copy_pkg::addr_t'(wr_index) * copy_pkg::addr_t'(`CU_LINE_BYTES);

	////////////////////////////////////////////////////////////
	// Held write request
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_req <= 1'b0;
		end else begin
			if (buf_pop)
				wr_req <= 1'b1;
			else if (wr_grant)
				wr_req <= 1'b0;
		end
	end

	// Line and index captured from the buffer head
	always_ff @(posedge clock) begin
		if (buf_pop) begin
			wr_data  <= head_data;
			wr_index <= head_index;
		end
	end

endmodule

// ==== testbench/copy_memory_model.sv ====
`timescale 1ns/10ps

module copy_memory_model #(
	parameter copy_pkg::line_t pattern_key = 64'h0,
	parameter int              seed_init   = 1
) (
	input  logic                clock,
	input  logic                cmd_valid,
	input  copy_pkg::cmd_kind_t cmd_kind,
	input  copy_pkg::addr_t     cmd_addr,
	input  copy_pkg::count_t    cmd_index,
	output logic                rdata_valid,
	output copy_pkg::line_t     rdata,
	output copy_pkg::count_t    rdata_index,
	output logic                wrsp_valid
);

	integer seed;
	int     cycle;
	int     last_ready;
	int     ready;

	// Pending read replies, oldest first
	int               rd_due     [$];
	copy_pkg::addr_t  rd_addr_q  [$];
	copy_pkg::count_t rd_index_q [$];

	// Cycles in which a write response is due
	int wr_due [$];

	// Contents of memory at every line address
	function automatic copy_pkg::line_t line_pattern(input copy_pkg::addr_t addr);
		line_pattern = {addr[31:0], addr[63:32]} ^ pattern_key;
	endfunction

	////////////////////////////////////////////////////////////
	// Reply side, driven just after the rising edge
	////////////////////////////////////////////////////////////

	initial begin
		seed        = seed_init;
		cycle       = 0;
		last_ready  = 0;
		rdata_valid = 1'b0;
		rdata       = '0;
		rdata_index = '0;
		wrsp_valid  = 1'b0;
		forever begin
			@(posedge clock);
			#1;
			cycle = cycle + 1;
			rdata_valid = 1'b0;
			if ((rd_due.size() > 0) && (rd_due[0] <= cycle)) begin
				rdata_valid = 1'b1;
				rdata       = line_pattern(rd_addr_q[0]);
				rdata_index = rd_index_q[0];
				void'(rd_due.pop_front());
				void'(rd_addr_q.pop_front());
				void'(rd_index_q.pop_front());
			end
			wrsp_valid = 1'b0;
			if ((wr_due.size() > 0) && (wr_due[0] <= cycle)) begin
				wrsp_valid = 1'b1;
				void'(wr_due.pop_front());
			end
		end
	end

	// Command capture in the middle of the cycle
	always @(negedge clock) begin
		if (cmd_valid) begin
			if (cmd_kind == copy_pkg::CMD_READ) begin
				// 1 to 6 cycles, never overtaking an earlier read
				ready = cycle + 1 + ($unsigned($random(seed)) % 6);
				if (ready <= last_ready)
					ready = last_ready + 1;
				last_ready = ready;
				rd_due.push_back(ready);
				rd_addr_q.push_back(cmd_addr);
				rd_index_q.push_back(cmd_index);
			end else begin
				wr_due.push_back(cycle + 2);
			end
		end
	end

endmodule

// ==== testbench/copy_unit_tb.sv ====
`timescale 1ns/10ps
`include "copy_settings.svh"

module copy_unit_tb;

	localparam int              CLK_PERIOD  = 40;
	localparam int              NUM_JOBS    = 6;
	localparam int              MAX_LINES   = 64;
	localparam int              SEED        = 32'h0a5f_e5fb;
	localparam copy_pkg::line_t PATTERN_KEY = 64'hc3a5_5a3c_0ff0_9669;

	logic                        clock;
	logic                        rstn;
	logic                        enabled;
	logic                        job_start;
	copy_pkg::addr_t             job_src;
	copy_pkg::addr_t             job_dst;
	copy_pkg::count_t            job_size;
	logic                        cmd_full;
	logic                        rdata_valid;
	copy_pkg::line_t             rdata;
	copy_pkg::count_t            rdata_index;
	logic                        wrsp_valid;
	logic                        cmd_valid;
	copy_pkg::cmd_kind_t         cmd_kind;
	copy_pkg::addr_t             cmd_addr;
	copy_pkg::count_t            cmd_index;
	copy_pkg::line_t             cmd_data;
	logic [2*`CU_COUNT_BITS-1:0] status;
	logic                        running;
	logic                        done;

	// Job table columns
	copy_pkg::addr_t src_tab        [NUM_JOBS];
	copy_pkg::addr_t dst_tab        [NUM_JOBS];
	int              size_tab       [NUM_JOBS];
	int              full_tab       [NUM_JOBS];
	bit              restart_tab    [NUM_JOBS];
	int              exp_reads_tab  [NUM_JOBS];
	int              exp_writes_tab [NUM_JOBS];
	bit              table_loaded;

	// Scoreboard of the job in flight
	copy_pkg::addr_t cur_src;
	copy_pkg::addr_t cur_dst;
	int              cur_size;
	int              full_pct;
	logic            full_prev;
	int              read_hits  [MAX_LINES];
	int              write_hits [MAX_LINES];
	int              read_total;
	int              write_total;
	int              resp_total;

	integer seed;
	int     error_count;
	int     tests_run;
	int     tests_failed;

	copy_unit_top copy_unit_top_inst (
		.clock      (clock      ),
		.rstn       (rstn       ),
		.enabled    (enabled    ),
		.job_start  (job_start  ),
		.job_src    (job_src    ),
		.job_dst    (job_dst    ),
		.job_size   (job_size   ),
		.cmd_full   (cmd_full   ),
		.rdata_valid(rdata_valid),
		.rdata      (rdata      ),
		.rdata_index(rdata_index),
		.wrsp_valid (wrsp_valid ),
		.cmd_valid  (cmd_valid  ),
		.cmd_kind   (cmd_kind   ),
		.cmd_addr   (cmd_addr   ),
		.cmd_index  (cmd_index  ),
		.cmd_data   (cmd_data   ),
		.status     (status     ),
		.running    (running    ),
		.done       (done       )
	);

	copy_memory_model #(
		.pattern_key(PATTERN_KEY),
		.seed_init  (SEED       )
	) copy_memory_model_inst (
		.clock      (clock      ),
		.cmd_valid  (cmd_valid  ),
		.cmd_kind   (cmd_kind   ),
		.cmd_addr   (cmd_addr   ),
		.cmd_index  (cmd_index  ),
		.rdata_valid(rdata_valid),
		.rdata      (rdata      ),
		.rdata_index(rdata_index),
		.wrsp_valid (wrsp_valid )
	);

	function automatic copy_pkg::line_t line_pattern(input copy_pkg::addr_t addr);
		line_pattern = {addr[31:0], addr[63:32]} ^ PATTERN_KEY;
	endfunction

	function automatic copy_pkg::addr_t line_addr(input copy_pkg::addr_t base, input int idx);
		line_addr = base + copy_pkg::addr_t'(idx) * `CU_LINE_BYTES;
	endfunction

	task automatic report_mismatch(input string name, input logic [63:0] got,
			input logic [63:0] expected);
		$display("Fail at %0d ns: %s got %h expected %h", $time, name, got, expected);
		error_count = error_count + 1;
	endtask

	task automatic set_job(input int row, input copy_pkg::addr_t src, input copy_pkg::addr_t dst,
			input int size, input int full, input bit restart, input int reads, input int writes);
		src_tab[row]        = src;
		dst_tab[row]        = dst;
		size_tab[row]       = size;
		full_tab[row]       = full;
		restart_tab[row]    = restart;
		exp_reads_tab[row]  = reads;
		exp_writes_tab[row] = writes;
	endtask

	// Row, source, destination, lines, cmd_full percent, restart, reads, writes
	task automatic load_jobs();
		set_job(0, 64'h0000_0000_0001_0000, 64'h0000_0000_0002_0000,  1,  0, 0,  1,  1);
		set_job(1, 64'h0000_0000_0010_0040, 64'h0000_0000_0020_0000, 12,  0, 0, 12, 12);
		set_job(2, 64'h0000_0001_0000_0000, 64'h0000_0001_8000_0008, 20, 40, 0, 20, 20);
		set_job(3, 64'hffff_ffff_ffff_ffe0, 64'h0000_0000_0000_1000,  6, 70, 0,  6,  6);
		set_job(4, 64'h0000_0000_0040_0000, 64'h0000_0000_0040_0100,  9, 25, 1,  9,  9);
		set_job(5, 64'h0000_0000_0050_0000, 64'h0000_0000_0060_0000, 16,  0, 0, 16, 16);
	endtask

	////////////////////////////////////////////////////////////
	// Clock, cmd_full and watchdog
	////////////////////////////////////////////////////////////

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	initial begin
		forever begin
			@(posedge clock);
			#1;
			cmd_full = (full_pct > 0) && (($unsigned($random(seed)) % 100) < full_pct);
		end
	end

	initial begin
		int total_lines;
		wait (table_loaded);
		total_lines = 0;
		for (int i = 0; i < NUM_JOBS; i++)
			total_lines = total_lines + size_tab[i];
		repeat (total_lines * 40 + 200) @(posedge clock);
		$display("Timeout: the job table did not complete in %0d cycles", total_lines * 40 + 200);
		$display("CHECKS FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Command bus monitor
	////////////////////////////////////////////////////////////

	task automatic check_command();
		copy_pkg::addr_t base;
		int              idx;
		idx  = cmd_index;
		base = (cmd_kind == copy_pkg::CMD_READ) ? cur_src : cur_dst;
		assert (cmd_addr == line_addr(base, idx))
		else report_mismatch("cmd_addr", cmd_addr, line_addr(base, idx));
		assert (idx < cur_size)
		else begin
			$display("Command index %0d lies outside a job of %0d lines", idx, cur_size);
			error_count = error_count + 1;
		end
		if (cmd_kind == copy_pkg::CMD_READ) begin
			read_total = read_total + 1;
			if (idx < MAX_LINES)
				read_hits[idx] = read_hits[idx] + 1;
		end else begin
			write_total = write_total + 1;
			if (idx < MAX_LINES)
				write_hits[idx] = write_hits[idx] + 1;
			assert (cmd_data == line_pattern(line_addr(cur_src, idx)))
			else report_mismatch("cmd_data", cmd_data, line_pattern(line_addr(cur_src, idx)));
		end
	endtask

	always @(negedge clock) begin
		if (rstn) begin
			// A full level stalls the bus in the following cycle
			assert (!(full_prev && cmd_valid))
			else report_mismatch("cmd_valid", cmd_valid, 1'b0);
			if (cmd_valid)
				check_command();
			if (wrsp_valid)
				resp_total = resp_total + 1;
		end
		full_prev = cmd_full;
	end

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	task automatic check_reset_state();
		int errors_before;
		errors_before = error_count;
		repeat (3) begin
			@(negedge clock);
			assert (cmd_valid == 1'b0) else report_mismatch("cmd_valid", cmd_valid, 1'b0);
			assert (done == 1'b0) else report_mismatch("done", done, 1'b0);
			assert (running == 1'b0) else report_mismatch("running", running, 1'b0);
			assert (status == '0) else report_mismatch("status", status, 64'h0);
		end
		tests_run = tests_run + 1;
		if (error_count != errors_before) begin
			tests_failed = tests_failed + 1;
			$display("Test reset state failed");
		end else begin
			$display("Test reset state passed");
		end
	endtask

	task automatic run_job(input int j);
		int                          errors_before;
		logic [2*`CU_COUNT_BITS-1:0] exp_status;
		errors_before = error_count;
		full_pct      = full_tab[j];
		@(posedge clock);
		#1;
		cur_src     = src_tab[j];
		cur_dst     = dst_tab[j];
		cur_size    = size_tab[j];
		read_total  = 0;
		write_total = 0;
		resp_total  = 0;
		for (int k = 0; k < MAX_LINES; k++) begin
			read_hits[k]  = 0;
			write_hits[k] = 0;
		end
		job_start = 1'b1;
		job_src   = src_tab[j];
		job_dst   = dst_tab[j];
		job_size  = size_tab[j];
		@(posedge clock);
		#1;
		job_start = 1'b0;

		// Second descriptor while busy has no effect
		if (restart_tab[j]) begin
			repeat (2) @(posedge clock);
			#1;
			assert (running)
			else begin
				$display("DUT was not running when the second job_start was given");
				error_count = error_count + 1;
			end
			job_start = 1'b1;
			job_src   = src_tab[j] ^ 64'h1000;
			job_dst   = dst_tab[j] ^ 64'h1000;
			job_size  = size_tab[j] + 4;
			@(posedge clock);
			#1;
			job_start = 1'b0;
		end

		@(negedge clock);
		while (!done)
			@(negedge clock);
		full_pct   = 0;
		exp_status = {copy_pkg::count_t'(exp_writes_tab[j]), copy_pkg::count_t'(exp_reads_tab[j])};
		assert (status == exp_status) else report_mismatch("status", status, exp_status);
		assert (!running) else report_mismatch("running", running, 1'b0);
		assert (read_total == exp_reads_tab[j])
		else report_mismatch("read command count", read_total, exp_reads_tab[j]);
		assert (write_total == exp_writes_tab[j])
		else report_mismatch("write command count", write_total, exp_writes_tab[j]);
		assert (resp_total == exp_writes_tab[j])
		else report_mismatch("wrsp_valid count", resp_total, exp_writes_tab[j]);
		for (int k = 0; k < cur_size; k++) begin
			assert ((read_hits[k] == 1) && (write_hits[k] == 1))
			else begin
				$display("Line %0d was read %0d times and written %0d times",
					k, read_hits[k], write_hits[k]);
				error_count = error_count + 1;
			end
		end

		tests_run = tests_run + 1;
		if (error_count != errors_before) begin
			tests_failed = tests_failed + 1;
			$display("Test job %0d (%0d lines) failed", j, cur_size);
		end else begin
			$display("Test job %0d (%0d lines) passed", j, cur_size);
		end
	endtask

	initial begin
		seed         = SEED;
		rstn         = 1'b0;
		enabled      = 1'b0;
		job_start    = 1'b0;
		job_src      = '0;
		job_dst      = '0;
		job_size     = '0;
		cmd_full     = 1'b0;
		full_pct     = 0;
		full_prev    = 1'b0;
		cur_src      = '0;
		cur_dst      = '0;
		cur_size     = 0;
		read_total   = 0;
		write_total  = 0;
		resp_total   = 0;
		error_count  = 0;
		tests_run    = 0;
		tests_failed = 0;
		load_jobs();
		table_loaded = 1'b1;

		repeat (2) @(posedge clock);
		#1;
		rstn    = 1'b1;
		enabled = 1'b1;
		check_reset_state();

		for (int j = 0; j < NUM_JOBS; j++)
			run_job(j);

		$display("Tests run %0d, tests failed %0d, check errors %0d",
			tests_run, tests_failed, error_count);
		if (error_count == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+rtl
rtl/copy_pkg.sv
rtl/copy_job_control.sv
rtl/copy_read_engine.sv
rtl/copy_line_buffer.sv
rtl/copy_write_engine.sv
rtl/command_arbiter.sv
rtl/copy_unit_top.sv
testbench/copy_memory_model.sv
testbench/copy_unit_tb.sv
